//--- verilog/rvCore_defines.svh
// Global constants for the RV32I core.
// Memory depths must be powers of two; the stages index them with
// address bits above bit 1, so all accesses are word-lane based.
// Both memories are small on-chip arrays without reset.

`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

//--- verilog/rvPkg.sv
// Shared types for the RV32I pipeline.
// Stage payloads are packed; an all-zero payload is a bubble
// because valid is cleared.

`default_nettype none

package rvPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdT;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB
  } aluOpT;

  // encoding follows funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    memByte = 2'b00,
    memHalf = 2'b01,
    memWord = 2'b10
  } memWidthT;

  typedef struct packed {
    logic valid;
    wordT pc;
    wordT inst;
  } ifIdT;

  typedef struct packed {
    logic     valid;
    wordT     pc;
    regIdT    rs1;
    regIdT    rs2;
    wordT     rs1Val;
    wordT     rs2Val;
    regIdT    rd;
    wordT     imm;
    aluOpT    aluOp;
    logic     useImm;
    logic     usePc;
    logic     isBranch;
    logic [2:0] brFunct;
    logic     isJal;
    logic     isJalr;
    logic     isLoad;
    logic     isStore;
    logic     regWe;
    memWidthT memWidth;
    logic     loadUnsigned;
    logic     isHalt;
    logic     isIllegal;
  } idExT;

  typedef struct packed {
    logic     valid;
    regIdT    rd;
    wordT     result;
    wordT     storeData;
    logic     isLoad;
    logic     isStore;
    memWidthT memWidth;
    logic     loadUnsigned;
    logic     regWe;
    logic     isHalt;
    logic     isIllegal;
  } exMemT;

endpackage

`default_nettype wire

//--- verilog/pipeReg.sv
// Generic stage register between two pipeline steps.
// rst and flush both load an all-zero payload, i.e. a bubble.
// No enable: there is no back-pressure in this core.

`default_nettype none

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    flush,
  input  payloadT dIn,
  output payloadT dOut
);

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      dOut <= '0;
    end else begin
      dOut <= dIn;
    end
  end

endmodule

`default_nettype wire

//--- verilog/fetchStage.sv
// Fetch step with the PC and the instruction memory.
// imemAddr is a byte address; only the word index bits are used.
// Load the program only while rst is high.
// The memory read is combinational, so fetch has no latency.

`default_nettype none

`include "rvCore_defines.svh"

module fetchStage (
  input  logic         clk,
  input  logic         rst,
  input  logic         imemWe,
  input  logic         redirect,
  input  rvPkg::wordT  imemAddr,
  input  rvPkg::wordT  imemData,
  input  rvPkg::wordT  redirectPc,
  output rvPkg::ifIdT  fetchOut
);

  localparam int IdxW = $clog2(`RV_IMEM_WORDS);

  rvPkg::wordT imem [`RV_IMEM_WORDS];
  rvPkg::wordT pc;
  rvPkg::wordT nextPc;

  // a redirect from execute wins over sequential fetch
  assign nextPc = redirect ? redirectPc : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

  // program load port
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr[IdxW+1:2]] <= imemData;
    end
  end

  // valid is low while rst is high
  // flushed slots are cleared in the ifId register
  always_comb begin
    fetchOut.valid = !rst;
    fetchOut.pc    = pc;
    fetchOut.inst  = imem[pc[IdxW+1:2]];
  end

endmodule

`default_nettype wire

//--- verilog/regFile.sv
// 32 x 32 integer register file, two read ports, one write port.
// x0 reads as zero and is never written.
// Reads bypass a write to the same register in the same cycle.

`default_nettype none

module regFile (
  input  logic          clk,
  input  logic          we,
  input  rvPkg::regIdT  rs1,
  input  rvPkg::regIdT  rs2,
  input  rvPkg::regIdT  rd,
  input  rvPkg::wordT   wdata,
  output rvPkg::wordT   rdata1,
  output rvPkg::wordT   rdata2
);

  rvPkg::wordT regs [32];

  always_ff @(posedge clk) begin
    if (we && rd != '0) begin
      regs[rd] <= wdata;
    end
  end

  // write-through covers the distance-2 dependency
  assign rdata1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wdata : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wdata : regs[rs2];

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
// RV32I decoder with immediate generation and register read.
// Supported: OP, OP-IMM, LUI, AUIPC, JAL, JALR, branches, loads,
// stores and EBREAK. Everything else is flagged illegal with no
// register write, memory access or redirect.
// Bubbles decode as the NOP, keeping valid low.

`default_nettype none

`include "rvCore_defines.svh"

module decodeStage (
  input  logic          clk,
  input  rvPkg::ifIdT   decIn,
  input  logic          wbValid,
  input  rvPkg::regIdT  wbRd,
  input  rvPkg::wordT   wbData,
  output rvPkg::idExT   decOut
);

  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpJalr   = 7'b1100111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpReg    = 7'b0110011;
  localparam logic [6:0] OpSystem = 7'b1110011;

  rvPkg::wordT  inst;
  logic [6:0]   opcode;
  logic [2:0]   funct3;
  logic [6:0]   funct7;
  rvPkg::wordT  immI;
  rvPkg::wordT  immS;
  rvPkg::wordT  immB;
  rvPkg::wordT  immU;
  rvPkg::wordT  immJ;
  logic         useRs1;
  logic         useRs2;
  rvPkg::regIdT rs1Id;
  rvPkg::regIdT rs2Id;
  rvPkg::wordT  rs1Val;
  rvPkg::wordT  rs2Val;
  rvPkg::aluOpT f3Op;
  logic         bad;

  assign inst   = decIn.valid ? decIn.inst : `RV_NOP;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // unused source ids read x0, so they never match a forward
  assign useRs1 = !(opcode == OpLui || opcode == OpAuipc || opcode == OpJal);
  assign useRs2 = (opcode == OpBranch || opcode == OpStore || opcode == OpReg);
  assign rs1Id  = useRs1 ? inst[19:15] : '0;
  assign rs2Id  = useRs2 ? inst[24:20] : '0;

  regFile u_regFile (
    .clk    (clk),
    .we     (wbValid),
    .rs1    (rs1Id),
    .rs2    (rs2Id),
    .rd     (wbRd),
    .wdata  (wbData),
    .rdata1 (rs1Val),
    .rdata2 (rs2Val)
  );

  // funct7[5] picks sub/sra; sub only exists for register ops
  always_comb begin
    case (funct3)
      3'b000:  f3Op = (opcode == OpReg && funct7[5]) ? rvPkg::aluSub : rvPkg::aluAdd;
      3'b001:  f3Op = rvPkg::aluSll;
      3'b010:  f3Op = rvPkg::aluSlt;
      3'b011:  f3Op = rvPkg::aluSltu;
      3'b100:  f3Op = rvPkg::aluXor;
      3'b101:  f3Op = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
      3'b110:  f3Op = rvPkg::aluOr;
      default: f3Op = rvPkg::aluAnd;
    endcase
  end

  always_comb begin
    bad                 = 1'b0;
    decOut              = '0;
    decOut.valid        = decIn.valid;
    decOut.pc           = decIn.pc;
    decOut.rs1          = rs1Id;
    decOut.rs2          = rs2Id;
    decOut.rs1Val       = rs1Val;
    decOut.rs2Val       = rs2Val;
    decOut.rd           = inst[11:7];
    decOut.aluOp        = rvPkg::aluAdd;
    decOut.brFunct      = funct3;
    decOut.memWidth     = rvPkg::memWidthT'(funct3[1:0]);
    decOut.loadUnsigned = funct3[2];
    case (opcode)
      OpLui: begin
        decOut.imm    = immU;
        decOut.useImm = 1'b1;
        decOut.aluOp  = rvPkg::aluPassB;
        decOut.regWe  = 1'b1;
      end
      OpAuipc: begin
        decOut.imm    = immU;
        decOut.useImm = 1'b1;
        decOut.usePc  = 1'b1;
        decOut.regWe  = 1'b1;
      end
      OpJal: begin
        decOut.imm   = immJ;
        decOut.isJal = 1'b1;
        decOut.regWe = 1'b1;
      end
      OpJalr: begin
        decOut.imm    = immI;
        decOut.useImm = 1'b1;
        decOut.isJalr = 1'b1;
        decOut.regWe  = 1'b1;
        bad           = (funct3 != 3'b000);
      end
      OpBranch: begin
        decOut.imm      = immB;
        decOut.isBranch = 1'b1;
        bad             = (funct3[2:1] == 2'b01);
      end
      OpLoad: begin
        decOut.imm    = immI;
        decOut.useImm = 1'b1;
        decOut.isLoad = 1'b1;
        decOut.regWe  = 1'b1;
        bad           = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
      end
      OpStore: begin
        decOut.imm     = immS;
        decOut.useImm  = 1'b1;
        decOut.isStore = 1'b1;
        bad            = funct3[2] || (funct3[1:0] == 2'b11);
      end
      OpImm: begin
        decOut.imm    = immI;
        decOut.useImm = 1'b1;
        decOut.aluOp  = f3Op;
        decOut.regWe  = 1'b1;
        if (funct3 == 3'b001) begin
          bad = (funct7 != 7'b0000000);
        end else if (funct3 == 3'b101) begin
          bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
        end
      end
      OpReg: begin
        decOut.aluOp = f3Op;
        decOut.regWe = 1'b1;
        bad = !(funct7 == 7'b0000000 ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OpSystem: begin
        // only ebreak is supported
        decOut.isHalt = (inst == 32'h0010_0073);
        bad           = (inst != 32'h0010_0073);
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      decOut.regWe     = 1'b0;
      decOut.isLoad    = 1'b0;
      decOut.isStore   = 1'b0;
      decOut.isBranch  = 1'b0;
      decOut.isJal     = 1'b0;
      decOut.isJalr    = 1'b0;
      decOut.isHalt    = 1'b0;
      decOut.isIllegal = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
// Execute step: forwarding, ALU, branch compare and redirect.
// Only the memory stage forwards; older results come through
// the register file write-through in decode.
// Branches and jumps redirect here, two slots after fetch.

`default_nettype none

module executeStage (
  input  rvPkg::idExT   exIn,
  input  logic          wbValid,
  input  rvPkg::regIdT  wbRd,
  input  rvPkg::wordT   wbData,
  output rvPkg::exMemT  exOut,
  output logic          redirect,
  output rvPkg::wordT   redirectPc
);

  rvPkg::wordT srcA;
  rvPkg::wordT srcB;
  rvPkg::wordT opA;
  rvPkg::wordT opB;
  rvPkg::wordT aluOut;
  rvPkg::wordT pcPlus4;
  rvPkg::wordT brTarget;
  logic        taken;

  // memory-stage result, also covers load-use since dmem is comb
  assign srcA = (wbValid && exIn.rs1 != '0 && wbRd == exIn.rs1) ? wbData : exIn.rs1Val;
  assign srcB = (wbValid && exIn.rs2 != '0 && wbRd == exIn.rs2) ? wbData : exIn.rs2Val;

  assign opA = exIn.usePc ? exIn.pc : srcA;
  assign opB = exIn.useImm ? exIn.imm : srcB;

  always_comb begin
    case (exIn.aluOp)
      rvPkg::aluAdd:   aluOut = opA + opB;
      rvPkg::aluSub:   aluOut = opA - opB;
      rvPkg::aluSll:   aluOut = opA << opB[4:0];
      rvPkg::aluSlt:   aluOut = {31'b0, $signed(opA) < $signed(opB)};
      rvPkg::aluSltu:  aluOut = {31'b0, opA < opB};
      rvPkg::aluXor:   aluOut = opA ^ opB;
      rvPkg::aluSrl:   aluOut = opA >> opB[4:0];
      rvPkg::aluSra:   aluOut = $signed(opA) >>> opB[4:0];
      rvPkg::aluOr:    aluOut = opA | opB;
      rvPkg::aluAnd:   aluOut = opA & opB;
      rvPkg::aluPassB: aluOut = opB;
      default:         aluOut = opA + opB;
    endcase
  end

  // branch conditions by funct3
  always_comb begin
    case (exIn.brFunct)
      3'b000:  taken = (srcA == srcB);
      3'b001:  taken = (srcA != srcB);
      3'b100:  taken = $signed(srcA) < $signed(srcB);
      3'b101:  taken = $signed(srcA) >= $signed(srcB);
      3'b110:  taken = srcA < srcB;
      3'b111:  taken = srcA >= srcB;
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4  = exIn.pc + 32'd4;
  assign brTarget = exIn.pc + exIn.imm;

  assign redirect = exIn.valid && (exIn.isJal || exIn.isJalr || (exIn.isBranch && taken));
  // jalr target is rs1 + imm from the ALU with bit 0 cleared
  assign redirectPc = exIn.isJalr ? {aluOut[31:1], 1'b0} : brTarget;

  always_comb begin
    exOut.valid        = exIn.valid;
    exOut.rd           = exIn.rd;
    exOut.result       = (exIn.isJal || exIn.isJalr) ? pcPlus4 : aluOut;
    exOut.storeData    = srcB;
    exOut.isLoad       = exIn.isLoad;
    exOut.isStore      = exIn.isStore;
    exOut.memWidth     = exIn.memWidth;
    exOut.loadUnsigned = exIn.loadUnsigned;
    exOut.regWe        = exIn.regWe;
    exOut.isHalt       = exIn.isHalt;
    exOut.isIllegal    = exIn.isIllegal;
  end

endmodule

`default_nettype wire

//--- verilog/memoryStage.sv
// Memory and writeback step with the data memory.
// Address bits above 1 index words; bits 1:0 only select lanes,
// misaligned accesses are not trapped. Halfwords use bit 1 only.
// Loads read combinationally and write back in the same cycle.

`default_nettype none

`include "rvCore_defines.svh"

module memoryStage (
  input  logic          clk,
  input  rvPkg::exMemT  memIn,
  output logic          wbValid,
  output rvPkg::regIdT  wbRd,
  output rvPkg::wordT   wbData,
  output logic          halt,
  output logic          illegal
);

  localparam int IdxW = $clog2(`RV_DMEM_WORDS);

  rvPkg::wordT     dmem [`RV_DMEM_WORDS];
  logic [IdxW-1:0] idx;
  logic [1:0]      laneOff;
  logic [3:0]      laneEn;
  rvPkg::wordT     wrData;
  rvPkg::wordT     rdWord;
  rvPkg::wordT     shifted;
  rvPkg::wordT     loadVal;

  assign idx = memIn.result[IdxW+1:2];

  always_comb begin
    case (memIn.memWidth)
      rvPkg::memByte: begin
        laneOff = memIn.result[1:0];
        laneEn  = 4'b0001 << laneOff;
        wrData  = {4{memIn.storeData[7:0]}};
      end
      rvPkg::memHalf: begin
        laneOff = {memIn.result[1], 1'b0};
        laneEn  = 4'b0011 << laneOff;
        wrData  = {2{memIn.storeData[15:0]}};
      end
      default: begin
        laneOff = 2'b00;
        laneEn  = 4'b1111;
        wrData  = memIn.storeData;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (memIn.valid && memIn.isStore) begin
      for (int i = 0; i < 4; i++) begin
        if (laneEn[i]) begin
          dmem[idx][8*i +: 8] <= wrData[8*i +: 8];
        end
      end
    end
  end

  // lane data moved down to bit 0, then extended
  assign rdWord  = dmem[idx];
  assign shifted = rdWord >> {laneOff, 3'b000};

  always_comb begin
    case (memIn.memWidth)
      rvPkg::memByte: loadVal = memIn.loadUnsigned ? {24'b0, shifted[7:0]}
                                                   : {{24{shifted[7]}}, shifted[7:0]};
      rvPkg::memHalf: loadVal = memIn.loadUnsigned ? {16'b0, shifted[15:0]}
                                                   : {{16{shifted[15]}}, shifted[15:0]};
      default:        loadVal = rdWord;
    endcase
  end

  assign wbValid = memIn.valid && memIn.regWe && memIn.rd != '0;
  assign wbRd    = memIn.rd;
  assign wbData  = memIn.isLoad ? loadVal : memIn.result;
  assign halt    = memIn.valid && memIn.isHalt;
  assign illegal = memIn.valid && memIn.isIllegal;

endmodule

`default_nettype wire

//--- verilog/rvCore.sv
// Top of the RV32I core: fetch, decode, execute, memory/writeback.
// Load the program through imemWe/imemAddr/imemData while rst is
// high. The core never stalls and does not stop on halt or illegal;
// those are one-cycle strobes and the environment ends the run.

`default_nettype none

module rvCore (
  input  logic          clk,
  input  logic          rst,
  input  logic          imemWe,
  input  rvPkg::wordT   imemAddr,
  input  rvPkg::wordT   imemData,
  output logic          wbValid,
  output rvPkg::regIdT  wbRd,
  output rvPkg::wordT   wbData,
  output logic          halt,
  output logic          illegal
);

  rvPkg::ifIdT  fetchOut;
  rvPkg::ifIdT  decIn;
  rvPkg::idExT  decOut;
  rvPkg::idExT  exIn;
  rvPkg::exMemT exOut;
  rvPkg::exMemT memIn;
  logic         redirect;
  rvPkg::wordT  redirectPc;

  fetchStage u_fetchStage (
    .clk        (clk),
    .rst        (rst),
    .imemWe     (imemWe),
    .redirect   (redirect),
    .imemAddr   (imemAddr),
    .imemData   (imemData),
    .redirectPc (redirectPc),
    .fetchOut   (fetchOut)
  );

  // redirect drops the two younger instructions
  pipeReg #(.payloadT(rvPkg::ifIdT)) ifIdReg (
    .clk   (clk),
    .rst   (rst),
    .flush (redirect),
    .dIn   (fetchOut),
    .dOut  (decIn)
  );

  decodeStage u_decodeStage (
    .clk     (clk),
    .decIn   (decIn),
    .wbValid (wbValid),
    .wbRd    (wbRd),
    .wbData  (wbData),
    .decOut  (decOut)
  );

  pipeReg #(.payloadT(rvPkg::idExT)) idExReg (
    .clk   (clk),
    .rst   (rst),
    .flush (redirect),
    .dIn   (decOut),
    .dOut  (exIn)
  );

  executeStage u_executeStage (
    .exIn       (exIn),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData),
    .exOut      (exOut),
    .redirect   (redirect),
    .redirectPc (redirectPc)
  );

  // the redirecting instruction itself still retires
  pipeReg #(.payloadT(rvPkg::exMemT)) exMemReg (
    .clk   (clk),
    .rst   (rst),
    .flush (1'b0),
    .dIn   (exOut),
    .dOut  (memIn)
  );

  memoryStage u_memoryStage (
    .clk     (clk),
    .memIn   (memIn),
    .wbValid (wbValid),
    .wbRd    (wbRd),
    .wbData  (wbData),
    .halt    (halt),
    .illegal (illegal)
  );

endmodule

`default_nettype wire

//--- test/rvCore_assert.sv
// Concurrent checks on the core's outputs, bound into rvCore.
// The reset check starts one cycle into reset, once the stage
// registers have been cleared.

`default_nettype none

module rvCore_assert (
  input logic         clk,
  input logic         rst,
  input logic         wbValid,
  input rvPkg::regIdT wbRd,
  input logic         halt,
  input logic         illegal,
  input rvPkg::wordT  pc
);
  timeunit 1ns;
  timeprecision 1ps;

  int assertFails = 0;

  noZeroWrite: assert property (@(posedge clk) disable iff (rst) wbValid |-> wbRd != '0)
    else begin
      assertFails++;
      $error("write strobe with x0 destination");
    end

  strobesExclusive: assert property (@(posedge clk) disable iff (rst) !(halt && illegal))
    else begin
      assertFails++;
      $error("halt and illegal high together");
    end

  quietInReset: assert property (@(posedge clk) rst && $past(rst) |-> !wbValid && !halt && !illegal)
    else begin
      assertFails++;
      $error("output strobe during reset");
    end

  pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else begin
      assertFails++;
      $error("fetch pc not word aligned");
    end

endmodule

bind rvCore rvCore_assert u_rvCore_assert (
  .clk     (clk),
  .rst     (rst),
  .wbValid (wbValid),
  .wbRd    (wbRd),
  .halt    (halt),
  .illegal (illegal),
  .pc      (u_fetchStage.pc)
);

`default_nettype wire

//--- test/rvCore_tb.sv
// Directed testbench for the RV32I core.
// Each test assembles a program with a small reference model that
// tracks registers and data memory, loads it while rst is high,
// then compares every retired write and the halt/illegal strobes.
// Register and data memory contents carry over between tests.

`default_nettype none

`include "rvCore_defines.svh"

module rvCore_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst;
  logic        imemWe;
  rvPkg::wordT imemAddr;
  rvPkg::wordT imemData;
  logic        wbValid;
  rvPkg::regIdT wbRd;
  rvPkg::wordT wbData;
  logic        halt;
  logic        illegal;

  rvPkg::wordT  prog[$];
  rvPkg::regIdT expRd[$];
  rvPkg::wordT  expVal[$];
  rvPkg::regIdT actRd[$];
  rvPkg::wordT  actVal[$];
  rvPkg::wordT  regs [32];
  logic [7:0]   dmemRef [1024];
  int           haltCount;
  int           illegalCount;
  int           expIllegal;
  int           errors;
  int           testErrors;
  int           testsRun;
  int           testsFailed;
  longint       deadline;
  integer       seed;
  string        curTest;

  rvCore u_rvCore (
    .clk      (clk),
    .rst      (rst),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbValid  (wbValid),
    .wbRd     (wbRd),
    .wbData   (wbData),
    .halt     (halt),
    .illegal  (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // retire monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (wbValid) begin
        actRd.push_back(wbRd);
        actVal.push_back(wbData);
      end
      if (halt) haltCount++;
      if (illegal) illegalCount++;
    end
  end

  // watchdog, deadline grows with each test
  initial begin
    deadline = 200;
    @(posedge clk);
    while ($time <= deadline) begin
      @(posedge clk);
    end
    $display("watchdog expired in %s, halt never seen", curTest);
    $display("test failed");
    $finish;
  end

  function automatic rvPkg::wordT sext12(logic [11:0] i);
    return {{20{i[11]}}, i};
  endfunction

  function automatic rvPkg::wordT aluRef(int f3, bit alt, rvPkg::wordT a, rvPkg::wordT b);
    case (f3)
      0: return alt ? a - b : a + b;
      1: return a << b[4:0];
      2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3: return (a < b) ? 32'd1 : 32'd0;
      4: return a ^ b;
      5: return alt ? rvPkg::wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rvPkg::wordT curPc();
    return 32'(prog.size() * 4);
  endfunction

  task automatic setReg(rvPkg::regIdT rd, rvPkg::wordT v);
    if (rd != 0) begin
      regs[rd] = v;
      expRd.push_back(rd);
      expVal.push_back(v);
    end
  endtask

  task automatic rOp(int f3, bit alt, rvPkg::regIdT rd, rvPkg::regIdT rs1, rvPkg::regIdT rs2);
    prog.push_back({alt ? 7'h20 : 7'h00, rs2, rs1, 3'(f3), rd, 7'h33});
    setReg(rd, aluRef(f3, alt, regs[rs1], regs[rs2]));
  endtask

  // shift immediates carry funct7 in imm[11:5]
  task automatic iOp(int f3, rvPkg::regIdT rd, rvPkg::regIdT rs1, logic [11:0] imm);
    prog.push_back({imm, rs1, 3'(f3), rd, 7'h13});
    setReg(rd, aluRef(f3, f3 == 5 && imm[10], regs[rs1], sext12(imm)));
  endtask

  task automatic store(int f3, rvPkg::regIdT rs2, rvPkg::regIdT rs1, logic [11:0] imm);
    rvPkg::wordT a;
    a = regs[rs1] + sext12(imm);
    prog.push_back({imm[11:5], rs2, rs1, 3'(f3), imm[4:0], 7'h23});
    for (int i = 0; i < (1 << f3); i++) begin
      dmemRef[(a[9:0] + i) % 1024] = regs[rs2][8*i +: 8];
    end
  endtask

  task automatic load(int f3, rvPkg::regIdT rd, rvPkg::regIdT rs1, logic [11:0] imm);
    rvPkg::wordT a;
    rvPkg::wordT w;
    a = regs[rs1] + sext12(imm);
    prog.push_back({imm, rs1, 3'(f3), rd, 7'h03});
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = dmemRef[(a[9:0] + i) % 1024];
    end
    case (f3)
      0: w = {{24{w[7]}}, w[7:0]};
      1: w = {{16{w[15]}}, w[15:0]};
      4: w = {24'b0, w[7:0]};
      5: w = {16'b0, w[15:0]};
      default: w = w;
    endcase
    setReg(rd, w);
  endtask

  // two slots that a taken jump must squash
  task automatic emitSlots();
    prog.push_back({12'h7ff, 5'd0, 3'd0, 5'd9, 7'h13});
    prog.push_back({12'h7ff, 5'd0, 3'd0, 5'd9, 7'h13});
  endtask

  // branch offset is always +12, over the two slots
  task automatic branch(int f3, rvPkg::regIdT rs1, rvPkg::regIdT rs2);
    logic t;
    case (f3)
      0: t = regs[rs1] == regs[rs2];
      1: t = regs[rs1] != regs[rs2];
      4: t = $signed(regs[rs1]) < $signed(regs[rs2]);
      5: t = $signed(regs[rs1]) >= $signed(regs[rs2]);
      6: t = regs[rs1] < regs[rs2];
      default: t = regs[rs1] >= regs[rs2];
    endcase
    prog.push_back({7'b0, rs2, rs1, 3'(f3), 5'b01100, 7'h63});
    if (t) begin
      emitSlots();
    end else begin
      iOp(0, 11, 11, 12'd1);
      iOp(0, 11, 11, 12'd1);
    end
    iOp(0, 10, 10, 12'd1);
  endtask

  task automatic checkWrite(rvPkg::regIdT eRd, rvPkg::regIdT aRd,
                            rvPkg::wordT eVal, rvPkg::wordT aVal);
    if (eRd !== aRd || eVal !== aVal) begin
      $display("[FAIL] %s: expected x%0d=%h, actual x%0d=%h", curTest, eRd, eVal, aRd, aVal);
      testErrors++;
    end
  endtask

  task automatic checkStrobe(string what, logic e, logic a);
    if (e !== a) begin
      $display("[FAIL] %s: %s expected %b, actual %b", curTest, what, e, a);
      testErrors++;
    end
  endtask

  task automatic startTest(string name);
    curTest = name;
    prog.delete();
    expRd.delete();
    expVal.delete();
    expIllegal = 0;
  endtask

  task automatic runTest();
    int cycles;
    int n;
    prog.push_back(32'h0010_0073);
    deadline = $time + 4 * (`RV_IMEM_WORDS + 10 + prog.size() + 30);
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < `RV_IMEM_WORDS; i++) begin
      @(posedge clk);
      imemWe   <= 1'b1;
      imemAddr <= 32'(i * 4);
      imemData <= (i < prog.size()) ? prog[i] : `RV_NOP;
    end
    @(posedge clk);
    imemWe <= 1'b0;
    repeat (4) @(posedge clk);
    actRd.delete();
    actVal.delete();
    haltCount    = 0;
    illegalCount = 0;
    testErrors   = 0;
    rst <= 1'b0;
    cycles = 0;
    while (haltCount == 0 && cycles < prog.size() + 30) begin
      @(posedge clk);
      cycles++;
    end
    // a few more cycles to catch late or repeated events
    repeat (4) @(posedge clk);
    n = (expRd.size() < actRd.size()) ? expRd.size() : actRd.size();
    for (int i = 0; i < n; i++) begin
      checkWrite(expRd[i], actRd[i], expVal[i], actVal[i]);
    end
    if (actRd.size() > expRd.size()) begin
      $display("%s: %0d extra register writes", curTest, actRd.size() - expRd.size());
      testErrors++;
    end else if (actRd.size() < expRd.size()) begin
      $display("%s: %0d register writes missing", curTest, expRd.size() - actRd.size());
      testErrors++;
    end
    checkStrobe("single halt pulse", 1'b1, haltCount == 1);
    checkStrobe("illegal pulse count", 1'b1, illegalCount == expIllegal);
    testsRun++;
    if (testErrors != 0) testsFailed++;
    errors += testErrors;
    $display("%s: %0d writes, %0d errors", curTest, actRd.size(), testErrors);
  endtask

  task automatic aluChains();
    startTest("alu chains");
    iOp(0, 1, 0, 12'd100);
    iOp(0, 2, 1, 12'hff6);
    rOp(0, 0, 3, 1, 2);
    rOp(0, 1, 4, 3, 1);
    iOp(1, 5, 4, 12'd3);
    rOp(5, 1, 6, 2, 1);
    iOp(0, 7, 0, 12'hf80);
    iOp(5, 6, 7, 12'h402);
    iOp(5, 5, 7, 12'd4);
    rOp(2, 0, 1, 7, 3);
    rOp(3, 0, 2, 7, 3);
    rOp(4, 0, 3, 5, 6);
    rOp(6, 0, 4, 3, 7);
    rOp(7, 0, 5, 4, 2);
    iOp(7, 6, 4, 12'h0f0);
    rOp(1, 0, 7, 6, 1);
    runTest();
  endtask

  task automatic loadStore();
    startTest("load store");
    iOp(0, 1, 0, 12'h040);
    prog.push_back({20'h8765f, 5'd2, 7'h37});
    setReg(2, 32'h8765_f000);
    iOp(0, 2, 2, 12'h3c4);
    store(2, 2, 1, 12'd0);
    store(1, 2, 1, 12'd6);
    store(0, 2, 1, 12'd9);
    store(0, 2, 1, 12'd8);
    // halfwords that complete the words at 68 and 72
    store(1, 2, 1, 12'd4);
    store(1, 2, 1, 12'd10);
    for (int f = 0; f < 6; f++) begin
      if (f != 3) begin
        load(f, 3, 1, 12'd0);
        load(f, 4, 1, (f == 2) ? 12'd4 : 12'd6);
        load(f, 5, 1, (f == 2) ? 12'd8 : ((f == 1 || f == 5) ? 12'd2 : 12'd3));
      end
    end
    load(2, 6, 1, 12'd0);
    rOp(0, 0, 7, 6, 6);
    load(0, 6, 1, 12'd9);
    iOp(0, 7, 6, 12'd1);
    runTest();
  endtask

  task automatic branches();
    startTest("branches");
    iOp(0, 1, 0, 12'd5);
    iOp(0, 2, 0, 12'hffd);
    iOp(0, 3, 0, 12'd5);
    iOp(0, 10, 0, 12'd0);
    iOp(0, 11, 0, 12'd0);
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        branch(k, 1, 3);
        branch(k, 1, 2);
        branch(k, 2, 1);
      end
    end
    runTest();
  endtask

  task automatic jumps();
    rvPkg::wordT pc;
    startTest("jumps");
    prog.push_back({20'habcde, 5'd5, 7'h37});
    setReg(5, 32'habcd_e000);
    pc = curPc();
    prog.push_back({20'h12345, 5'd6, 7'h17});
    setReg(6, pc + 32'h1234_5000);
    iOp(0, 0, 5, 12'd7);
    pc = curPc();
    prog.push_back({1'b0, 10'd6, 1'b0, 8'd0, 5'd7, 7'h6f});
    setReg(7, pc + 4);
    emitSlots();
    iOp(0, 12, 0, 12'd1);
    // odd target, bit 0 must be cleared
    iOp(0, 5, 0, 12'(curPc() + 4 + 12 + 1));
    pc = curPc();
    prog.push_back({12'd0, 5'd5, 3'd0, 5'd8, 7'h67});
    setReg(8, pc + 4);
    emitSlots();
    iOp(0, 12, 12, 12'd2);
    prog.push_back({1'b0, 10'd6, 1'b0, 8'd0, 5'd0, 7'h6f});
    emitSlots();
    iOp(0, 13, 12, 12'd3);
    runTest();
  endtask

  task automatic haltIllegal();
    startTest("halt and illegal");
    iOp(0, 14, 0, 12'd1);
    prog.push_back(32'hffff_ffff);
    expIllegal = 1;
    iOp(0, 15, 14, 12'd7);
    runTest();
  endtask

  task automatic randomAlu();
    int f3;
    bit alt;
    startTest("random alu");
    for (int r = 1; r < 8; r++) begin
      iOp(0, 5'(r), 0, 12'($random(seed)));
    end
    for (int i = 0; i < 40; i++) begin
      f3  = $unsigned($random(seed)) % 8;
      alt = (f3 == 0 || f3 == 5) ? $random(seed) : 1'b0;
      rOp(f3, alt, 5'($unsigned($random(seed)) % 7 + 1),
          5'($unsigned($random(seed)) % 7 + 1), 5'($unsigned($random(seed)) % 7 + 1));
    end
    runTest();
  endtask

  initial begin
    rst         = 1'b1;
    imemWe      = 1'b0;
    imemAddr    = '0;
    imemData    = '0;
    seed        = 10;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    curTest     = "reset";
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    aluChains();
    loadStore();
    branches();
    jumps();
    haltIllegal();
    randomAlu();
    if (u_rvCore.u_rvCore_assert.assertFails != 0) begin
      $display("%0d assertion failures", u_rvCore.u_rvCore_assert.assertFails);
      errors += u_rvCore.u_rvCore_assert.assertFails;
    end
    $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/rvPkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/rvCore.sv
test/rvCore_assert.sv
test/rvCore_tb.sv

//--- Bender.yml
package:
  name: rvCore

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rvPkg.sv
      - verilog/pipeReg.sv
      - verilog/fetchStage.sv
      - verilog/regFile.sv
      - verilog/decodeStage.sv
      - verilog/executeStage.sv
      - verilog/memoryStage.sv
      - verilog/rvCore.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/rvCore_assert.sv
      - test/rvCore_tb.sv
